//--- mem_sched.f
verilog/mem_sched_pkg.sv
verilog/sched_ifs.sv
verilog/req_queue.sv
verilog/rsp_slots.sv
verilog/batch_dispatch.sv
verilog/bank_rsp_select.sv
verilog/rsp_merge.sv
verilog/mem_sched.sv
bench/mem_sched_asserts.sv
bench/mem_sched_check.sv
bench/mem_sched_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = mem_sched_tb
FILELIST = mem_sched.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF "Simulation finished: PASS"

clean:
	rm -rf $(BUILD)

//--- bench/mem_sched_tb.sv
/*
 * Memory scheduler testbench
 * Random core requests from an LFSR and a banked memory model with random stalls
 */
`default_nettype none

module mem_sched_tb;
    import mem_sched_pkg::*;

    localparam int NUM_TESTS = 300;
    localparam int WAIT_MAX  = 400;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic req_valid, req_rw, req_ready, req_empty, rsp_valid, rsp_ready;
    lane_mask_t   req_mask, rsp_mask;
    lane_byteen_t req_byteen;
    lane_addr_t   req_addr;
    lane_data_t   req_data, rsp_data;
    logic [TAG_W-1:0] req_tag, rsp_tag;
    bank_mask_t   mem_req_valid, mem_req_rw, mem_req_ready, mem_rsp_valid, mem_rsp_ready;
    bank_byteen_t mem_req_byteen;
    bank_addr_t   mem_req_addr;
    bank_data_t   mem_req_data, mem_rsp_data;
    bank_tag_t    mem_req_tag, mem_rsp_tag;

    logic [31:0] lfsr = 32'hf56d;
    int cycle = 0;
    int bench_errors = 0;
    int error_count, read_count, rsp_count;
    int waited;
    logic accepted;
    logic timed_out = 1'b0;

    // Shared address space seen by every bank, with per-bank response FIFOs
    logic [DATA_W-1:0]    bank_mem [64];
    logic [DATA_W-1:0]    q_data [NUM_BANKS][$];
    logic [MEM_TAG_W-1:0] q_tag  [NUM_BANKS][$];
    int                   q_due  [NUM_BANKS][$];
    bank_mask_t           rsp_taken = '0;

    always #4 clk = ~clk;

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    mem_sched i_mem_sched (.*);

    bind mem_sched mem_sched_asserts i_mem_sched_asserts (
        .clk, .reset, .req_valid, .req_ready, .req_mask, .mem_req_valid, .mem_req_ready,
        .mem_req_rw, .mem_req_byteen, .mem_req_addr, .mem_req_data, .mem_req_tag,
        .rsp_valid, .rsp_ready, .rsp_mask, .rsp_data, .rsp_tag
    );

    mem_sched_check i_check (
        .clk, .reset, .req_valid, .req_ready, .req_rw, .req_mask, .req_byteen,
        .req_addr, .req_data, .req_tag, .rsp_valid, .rsp_ready, .rsp_mask,
        .rsp_data, .rsp_tag, .error_count, .read_count, .rsp_count
    );

    initial begin
        for (int a = 0; a < 64; a++) begin
            bank_mem[a] = 16'(a * 16'h9e37) ^ 16'h5a5a;
        end
    end

    // Bank handshakes sampled mid-cycle where all signals are settled
    always @(negedge clk) begin
        if (!reset) begin
            for (int j = 0; j < NUM_BANKS; j++) begin
                if (mem_req_valid[j] && mem_req_ready[j]) begin
                    if (mem_req_rw[j]) begin
                        for (int b = 0; b < BYTEEN_W; b++) begin
                            if (mem_req_byteen[j][b]) begin
                                bank_mem[mem_req_addr[j][5:0]][8*b +: 8] =
                                    mem_req_data[j][8*b +: 8];
                            end
                        end
                    end else begin
                        q_data[j].push_back(bank_mem[mem_req_addr[j][5:0]]);
                        q_tag[j].push_back(mem_req_tag[j]);
                        q_due[j].push_back(cycle + int'(rand_bits(3)));
                    end
                end
                rsp_taken[j] = mem_rsp_valid[j] && mem_rsp_ready[j];
            end
        end
    end

    always @(posedge clk) begin
        #2;
        cycle++;
        rsp_ready = (rand_bits(2) != 0);
        for (int j = 0; j < NUM_BANKS; j++) begin
            if (rsp_taken[j]) begin
                void'(q_data[j].pop_front());
                void'(q_tag[j].pop_front());
                void'(q_due[j].pop_front());
            end
            rsp_taken[j] = 1'b0;
            mem_req_ready[j] = (rand_bits(2) != 0);
            mem_rsp_valid[j] = !reset && (q_due[j].size() > 0) && (cycle >= q_due[j][0]);
            mem_rsp_data[j]  = mem_rsp_valid[j] ? q_data[j][0] : '0;
            mem_rsp_tag[j]   = mem_rsp_valid[j] ? q_tag[j][0] : '0;
        end
    end

    initial begin
        req_valid     = 1'b0;
        req_rw        = 1'b0;
        req_mask      = '0;
        req_byteen    = '0;
        req_addr      = '0;
        req_data      = '0;
        req_tag       = '0;
        rsp_ready     = 1'b0;
        mem_req_ready = '0;
        mem_rsp_valid = '0;
        mem_rsp_data  = '0;
        mem_rsp_tag   = '0;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        if (req_empty !== 1'b1) begin
            $display("Error: req_empty expected %h got %h", 1'b1, req_empty);
            bench_errors++;
        end
        if (rsp_valid !== 1'b0) begin
            $display("Error: rsp_valid expected %h got %h", 1'b0, rsp_valid);
            bench_errors++;
        end
        if (mem_req_valid !== '0) begin
            $display("Error: mem_req_valid expected %h got %h", 2'b00, mem_req_valid);
            bench_errors++;
        end
        @(posedge clk);
        #1;
        for (int n = 0; n < NUM_TESTS && !timed_out; n++) begin
            req_rw   = 1'(rand_bits(1));
            req_mask = NUM_REQS'(rand_bits(NUM_REQS));
            if (req_mask == '0) begin
                req_mask = 4'b1000;
            end
            // Low address bits follow the lane so lanes never share a word
            for (int l = 0; l < NUM_REQS; l++) begin
                req_byteen[l] = BYTEEN_W'(rand_bits(BYTEEN_W));
                req_addr[l]   = {10'b0, 4'(rand_bits(4)), 2'(l)};
                req_data[l]   = rand_bits(DATA_W);
            end
            req_valid = 1'b1;
            accepted  = 1'b0;
            waited    = 0;
            while (!accepted && waited < WAIT_MAX) begin
                @(negedge clk);
                accepted = req_ready;
                @(posedge clk);
                #1;
                waited++;
            end
            if (!accepted) begin
                $display("Timeout: request %0d was never accepted", n);
                timed_out = 1'b1;
            end
            req_valid = 1'b0;
            req_tag   = req_tag + 1'b1;
        end
        waited = 0;
        while (!(req_empty && !rsp_valid) && waited < WAIT_MAX && !timed_out) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= WAIT_MAX) begin
            $display("Timeout: traffic did not drain, req_empty stayed low");
            timed_out = 1'b1;
        end
        repeat (2) @(posedge clk);
        if (rsp_count != read_count) begin
            $display("Error: rsp_count expected %h got %h", read_count, rsp_count);
            bench_errors++;
        end
        $display("Errors %0d (checker %0d, bench %0d), reads %0d, responses %0d",
                 error_count + bench_errors, error_count, bench_errors, read_count, rsp_count);
        if (error_count == 0 && bench_errors == 0 && !timed_out) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/mem_sched_check.sv
/*
 * Core response checker
 * Replays accepted requests on a reference memory and compares each response
 */
`default_nettype none

module mem_sched_check (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              req_valid,
    input  wire                              req_ready,
    input  wire                              req_rw,
    input  wire mem_sched_pkg::lane_mask_t   req_mask,
    input  wire mem_sched_pkg::lane_byteen_t req_byteen,
    input  wire mem_sched_pkg::lane_addr_t   req_addr,
    input  wire mem_sched_pkg::lane_data_t   req_data,
    input  wire [mem_sched_pkg::TAG_W-1:0]   req_tag,
    input  wire                              rsp_valid,
    input  wire                              rsp_ready,
    input  wire mem_sched_pkg::lane_mask_t   rsp_mask,
    input  wire mem_sched_pkg::lane_data_t   rsp_data,
    input  wire [mem_sched_pkg::TAG_W-1:0]   rsp_tag,
    output int                               error_count,
    output int                               read_count,
    output int                               rsp_count
);
    import mem_sched_pkg::*;

    logic [DATA_W-1:0]  ref_mem [64];
    lane_mask_t         exp_mask [2**TAG_W];
    lane_data_t         exp_data [2**TAG_W];
    logic [2**TAG_W-1:0] pending = '0;

    initial begin
        error_count = 0;
        read_count  = 0;
        rsp_count   = 0;
        for (int a = 0; a < 64; a++) begin
            ref_mem[a] = 16'(a * 16'h9e37) ^ 16'h5a5a;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            // Response first, its tag may be reused in the same cycle
            if (rsp_valid && rsp_ready) begin
                rsp_count++;
                if (!pending[rsp_tag]) begin
                    $display("Response with tag %h arrived without an outstanding read", rsp_tag);
                    error_count++;
                end else begin
                    if (rsp_mask != exp_mask[rsp_tag]) begin
                        $display("Error: rsp_mask tag %h expected %h got %h",
                                 rsp_tag, exp_mask[rsp_tag], rsp_mask);
                        error_count++;
                    end
                    for (int l = 0; l < NUM_REQS; l++) begin
                        if (exp_mask[rsp_tag][l] && rsp_data[l] != exp_data[rsp_tag][l]) begin
                            $display("Error: rsp_data[%0d] tag %h expected %h got %h",
                                     l, rsp_tag, exp_data[rsp_tag][l], rsp_data[l]);
                            error_count++;
                        end
                    end
                    pending[rsp_tag] = 1'b0;
                end
            end
            if (req_valid && req_ready) begin
                for (int l = 0; l < NUM_REQS; l++) begin
                    if (req_mask[l] && req_rw) begin
                        for (int b = 0; b < BYTEEN_W; b++) begin
                            if (req_byteen[l][b]) begin
                                ref_mem[req_addr[l][5:0]][8*b +: 8] = req_data[l][8*b +: 8];
                            end
                        end
                    end
                    if (!req_rw) begin
                        exp_data[req_tag][l] = req_mask[l] ? ref_mem[req_addr[l][5:0]] : '0;
                    end
                end
                if (!req_rw) begin
                    if (pending[req_tag]) begin
                        $display("Read tag %h reused while still outstanding", req_tag);
                        error_count++;
                    end
                    pending[req_tag]  = 1'b1;
                    exp_mask[req_tag] = req_mask;
                    read_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/mem_sched_asserts.sv
/*
 * Handshake assertions bound to the scheduler top level
 */
`default_nettype none

module mem_sched_asserts (
    input wire                               clk,
    input wire                               reset,
    input wire                               req_valid,
    input wire                               req_ready,
    input wire mem_sched_pkg::lane_mask_t    req_mask,
    input wire mem_sched_pkg::bank_mask_t    mem_req_valid,
    input wire mem_sched_pkg::bank_mask_t    mem_req_ready,
    input wire mem_sched_pkg::bank_mask_t    mem_req_rw,
    input wire mem_sched_pkg::bank_byteen_t  mem_req_byteen,
    input wire mem_sched_pkg::bank_addr_t    mem_req_addr,
    input wire mem_sched_pkg::bank_data_t    mem_req_data,
    input wire mem_sched_pkg::bank_tag_t     mem_req_tag,
    input wire                               rsp_valid,
    input wire                               rsp_ready,
    input wire mem_sched_pkg::lane_mask_t    rsp_mask,
    input wire mem_sched_pkg::lane_data_t    rsp_data,
    input wire [mem_sched_pkg::TAG_W-1:0]    rsp_tag
);
    import mem_sched_pkg::*;

    a_req_mask: assert property (@(posedge clk) disable iff (reset)
        req_valid && req_ready |-> req_mask != '0)
        else $error("accepted request with an empty lane mask");

    for (genvar j = 0; j < NUM_BANKS; j++) begin : g_bank
        a_req_hold: assert property (@(posedge clk) disable iff (reset)
            mem_req_valid[j] && !mem_req_ready[j] |=> mem_req_valid[j]
            && $stable(mem_req_addr[j]) && $stable(mem_req_data[j]) && $stable(mem_req_tag[j])
            && $stable(mem_req_rw[j]) && $stable(mem_req_byteen[j]))
            else $error("bank %0d request changed before it was accepted", j);
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid
        && $stable(rsp_mask) && $stable(rsp_data) && $stable(rsp_tag))
        else $error("core response changed while stalled");

endmodule

`default_nettype wire

//--- verilog/mem_sched.sv
/*
 * Memory request scheduler top level
 * Queues core lane requests, spreads them over the banks in batches
 * and merges the bank read data back into one core response
 */
`default_nettype none

module mem_sched (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              req_valid,
    input  wire                              req_rw,
    input  wire mem_sched_pkg::lane_mask_t   req_mask,
    input  wire mem_sched_pkg::lane_byteen_t req_byteen,
    input  wire mem_sched_pkg::lane_addr_t   req_addr,
    input  wire mem_sched_pkg::lane_data_t   req_data,
    input  wire [mem_sched_pkg::TAG_W-1:0]   req_tag,
    output logic                             req_ready,
    output logic                             req_empty,
    output logic                             rsp_valid,
    output mem_sched_pkg::lane_mask_t        rsp_mask,
    output mem_sched_pkg::lane_data_t        rsp_data,
    output logic [mem_sched_pkg::TAG_W-1:0]  rsp_tag,
    input  wire                              rsp_ready,
    output mem_sched_pkg::bank_mask_t        mem_req_valid,
    output mem_sched_pkg::bank_mask_t        mem_req_rw,
    output mem_sched_pkg::bank_byteen_t      mem_req_byteen,
    output mem_sched_pkg::bank_addr_t        mem_req_addr,
    output mem_sched_pkg::bank_data_t        mem_req_data,
    output mem_sched_pkg::bank_tag_t         mem_req_tag,
    input  wire mem_sched_pkg::bank_mask_t   mem_req_ready,
    input  wire mem_sched_pkg::bank_mask_t   mem_rsp_valid,
    input  wire mem_sched_pkg::bank_data_t   mem_rsp_data,
    input  wire mem_sched_pkg::bank_tag_t    mem_rsp_tag,
    output mem_sched_pkg::bank_mask_t        mem_rsp_ready
);
    import mem_sched_pkg::*;

    queue_head_if head_bus ();
    mem_rsp_if    rsp_bus ();

    logic              alloc;
    lane_mask_t        alloc_mask;
    logic [TAG_W-1:0]  alloc_tag;
    logic [SLOT_W-1:0] free_slot;
    logic              slots_full;
    logic              slots_idle;
    logic              queue_empty;
    logic              release_en;
    logic [SLOT_W-1:0] release_slot;
    logic [SLOT_W-1:0] lookup_slot;
    logic [TAG_W-1:0]  lookup_tag;

    assign req_empty = queue_empty && slots_idle;

    req_queue i_req_queue (
        .clk, .reset, .req_valid, .req_rw, .req_mask, .req_byteen, .req_addr,
        .req_data, .req_tag, .free_slot, .slots_full, .req_ready, .alloc,
        .alloc_mask, .alloc_tag, .queue_empty, .head (head_bus.source)
    );

    rsp_slots i_rsp_slots (
        .clk, .reset, .alloc, .alloc_tag, .release_en, .release_slot,
        .lookup_slot, .free_slot, .slots_full, .slots_idle, .lookup_tag
    );

    batch_dispatch i_batch_dispatch (
        .clk, .reset, .mem_req_ready, .head (head_bus.sink), .mem_req_valid,
        .mem_req_rw, .mem_req_byteen, .mem_req_addr, .mem_req_data, .mem_req_tag
    );

    bank_rsp_select i_bank_rsp_select (
        .mem_rsp_valid, .mem_rsp_data, .mem_rsp_tag, .mem_rsp_ready,
        .sel (rsp_bus.source)
    );

    rsp_merge i_rsp_merge (
        .clk, .reset, .alloc, .free_slot, .alloc_mask, .lookup_tag, .rsp_ready,
        .sel (rsp_bus.sink), .lookup_slot, .release_en, .release_slot,
        .rsp_valid, .rsp_mask, .rsp_data, .rsp_tag
    );

endmodule

`default_nettype wire

//--- verilog/rsp_merge.sv
/*
 * Response merger
 * Collects bank responses per slot and emits one core response when complete
 */
`default_nettype none

module rsp_merge (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              alloc,
    input  wire [mem_sched_pkg::SLOT_W-1:0]  free_slot,
    input  wire mem_sched_pkg::lane_mask_t   alloc_mask,
    input  wire [mem_sched_pkg::TAG_W-1:0]   lookup_tag,
    input  wire                              rsp_ready,
    mem_rsp_if.sink                          sel,
    output logic [mem_sched_pkg::SLOT_W-1:0] lookup_slot,
    output logic                             release_en,
    output logic [mem_sched_pkg::SLOT_W-1:0] release_slot,
    output logic                             rsp_valid,
    output mem_sched_pkg::lane_mask_t        rsp_mask,
    output mem_sched_pkg::lane_data_t        rsp_data,
    output logic [mem_sched_pkg::TAG_W-1:0]  rsp_tag
);
    import mem_sched_pkg::*;

    lane_mask_t         orig_mask [QUEUE_SIZE];
    lane_mask_t         rem_mask  [QUEUE_SIZE];
    lane_data_t         store     [QUEUE_SIZE];

    logic [SLOT_W-1:0]  slot;
    logic [BATCH_W-1:0] batch;
    lane_mask_t         cur_lanes;
    lane_mask_t         rem_next;
    lane_data_t         merged;
    logic               complete;
    logic               fire;

    assign slot  = sel.tag[SLOT_W-1:0];
    assign batch = sel.tag[MEM_TAG_W-1 -: BATCH_W];

    always_comb begin
        merged = store[slot];
        for (int r = 0; r < NUM_REQS; r++) begin
            cur_lanes[r] = (BATCH_W'(r / NUM_BANKS) == batch) && sel.bank_mask[r % NUM_BANKS];
            if (cur_lanes[r]) begin
                merged[r] = sel.data[r % NUM_BANKS];
            end
        end
    end

    assign rem_next = rem_mask[slot] & ~cur_lanes;
    assign complete = (rem_next == '0);

    // Only the completing response needs room in the output register
    assign sel.ready    = !rsp_valid || rsp_ready || !complete;
    assign fire         = sel.valid && sel.ready;
    assign lookup_slot  = slot;
    assign release_en   = fire && complete;
    assign release_slot = slot;

    always_ff @(posedge clk) begin
        if (alloc) begin
            orig_mask[free_slot] <= alloc_mask;
            rem_mask[free_slot]  <= alloc_mask;
        end
        if (fire) begin
            rem_mask[slot] <= rem_next;
            store[slot]    <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (release_en) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (release_en) begin
            rsp_mask <= orig_mask[slot];
            rsp_data <= merged;
            rsp_tag  <= lookup_tag;
        end
    end

endmodule

`default_nettype wire

//--- verilog/bank_rsp_select.sv
/*
 * Bank response selector
 * Picks the tag of the lowest valid bank and groups all banks carrying it
 */
`default_nettype none

module bank_rsp_select (
    input  wire mem_sched_pkg::bank_mask_t  mem_rsp_valid,
    input  wire mem_sched_pkg::bank_data_t  mem_rsp_data,
    input  wire mem_sched_pkg::bank_tag_t   mem_rsp_tag,
    output mem_sched_pkg::bank_mask_t       mem_rsp_ready,
    mem_rsp_if.source                       sel
);
    import mem_sched_pkg::*;

    logic [MEM_TAG_W-1:0] sel_tag;
    bank_mask_t           match;

    always_comb begin
        sel_tag = '0;
        for (int j = NUM_BANKS - 1; j >= 0; j--) begin
            if (mem_rsp_valid[j]) begin
                sel_tag = mem_rsp_tag[j];
            end
        end
        for (int j = 0; j < NUM_BANKS; j++) begin
            match[j] = mem_rsp_valid[j] && (mem_rsp_tag[j] == sel_tag);
        end
    end

    assign sel.valid     = |mem_rsp_valid;
    assign sel.bank_mask = match;
    assign sel.data      = mem_rsp_data;
    assign sel.tag       = sel_tag;

    // Other banks wait for a later cycle
    assign mem_rsp_ready = match & {NUM_BANKS{sel.ready}};

endmodule

`default_nettype wire

//--- verilog/batch_dispatch.sv
/*
 * Bank batch dispatcher
 * Sends the queue head to the banks one batch at a time, skipping empty batches
 */
`default_nettype none

module batch_dispatch (
    input  wire                                clk,
    input  wire                                reset,
    input  wire mem_sched_pkg::bank_mask_t     mem_req_ready,
    queue_head_if.sink                         head,
    output mem_sched_pkg::bank_mask_t          mem_req_valid,
    output mem_sched_pkg::bank_mask_t          mem_req_rw,
    output mem_sched_pkg::bank_byteen_t        mem_req_byteen,
    output mem_sched_pkg::bank_addr_t          mem_req_addr,
    output mem_sched_pkg::bank_data_t          mem_req_data,
    output mem_sched_pkg::bank_tag_t           mem_req_tag
);
    import mem_sched_pkg::*;

    logic [NUM_BATCHES-1:0][NUM_BANKS-1:0] batch_mask;
    logic [NUM_BATCHES-1:0] batch_busy;
    logic [BATCH_W-1:0]     batch_idx;
    logic [BATCH_W-1:0]     cur_idx;
    logic [BATCH_W-1:0]     first_idx;
    logic [BATCH_W-1:0]     last_idx;
    logic [BATCH_W-1:0]     next_idx;
    bank_mask_t             sent_mask;
    bank_mask_t             sent_next;
    logic                   batch_done;
    logic                   last_batch;

    always_comb begin
        for (int b = 0; b < NUM_BATCHES; b++) begin
            for (int j = 0; j < NUM_BANKS; j++) begin
                if (b * NUM_BANKS + j < NUM_REQS) begin
                    batch_mask[b][j] = head.mask[b * NUM_BANKS + j];
                end else begin
                    batch_mask[b][j] = 1'b0;
                end
            end
            batch_busy[b] = |batch_mask[b];
        end
    end

    // Index register only holds 0 or a non-empty batch, so clamp to the first one
    always_comb begin
        first_idx = '0;
        last_idx  = '0;
        for (int b = NUM_BATCHES - 1; b >= 0; b--) begin
            if (batch_busy[b]) begin
                first_idx = BATCH_W'(b);
            end
        end
        for (int b = 0; b < NUM_BATCHES; b++) begin
            if (batch_busy[b]) begin
                last_idx = BATCH_W'(b);
            end
        end
        cur_idx  = (batch_idx < first_idx) ? first_idx : batch_idx;
        next_idx = last_idx;
        for (int b = NUM_BATCHES - 1; b >= 0; b--) begin
            if (batch_busy[b] && (BATCH_W'(b) > cur_idx)) begin
                next_idx = BATCH_W'(b);
            end
        end
    end

    assign mem_req_valid = {NUM_BANKS{head.valid}} & batch_mask[cur_idx] & ~sent_mask;
    assign sent_next     = sent_mask | (mem_req_valid & mem_req_ready);
    assign batch_done    = head.valid && ((batch_mask[cur_idx] & ~sent_next) == '0);
    assign last_batch    = (cur_idx == last_idx);
    assign head.pop      = batch_done && last_batch;

    always_comb begin
        int lane;
        for (int j = 0; j < NUM_BANKS; j++) begin
            lane = int'(cur_idx) * NUM_BANKS + j;
            mem_req_rw[j]  = head.rw;
            mem_req_tag[j] = {cur_idx, head.slot};
            if (lane < NUM_REQS) begin
                mem_req_byteen[j] = head.byteen[lane];
                mem_req_addr[j]   = head.addr[lane];
                mem_req_data[j]   = head.data[lane];
            end else begin
                mem_req_byteen[j] = '0;
                mem_req_addr[j]   = '0;
                mem_req_data[j]   = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            batch_idx <= '0;
            sent_mask <= '0;
        end else if (batch_done) begin
            sent_mask <= '0;
            batch_idx <= last_batch ? '0 : next_idx;
        end else if (head.valid) begin
            sent_mask <= sent_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rsp_slots.sv
/*
 * Response slot pool
 * In-use bit and core tag per slot, lowest free slot offered for allocation
 */
`default_nettype none

module rsp_slots (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              alloc,
    input  wire [mem_sched_pkg::TAG_W-1:0]   alloc_tag,
    input  wire                              release_en,
    input  wire [mem_sched_pkg::SLOT_W-1:0]  release_slot,
    input  wire [mem_sched_pkg::SLOT_W-1:0]  lookup_slot,
    output logic [mem_sched_pkg::SLOT_W-1:0] free_slot,
    output logic                             slots_full,
    output logic                             slots_idle,
    output logic [mem_sched_pkg::TAG_W-1:0]  lookup_tag
);
    import mem_sched_pkg::*;

    logic [QUEUE_SIZE-1:0] in_use;
    logic [TAG_W-1:0]      tag_store [QUEUE_SIZE];

    always_comb begin
        free_slot = '0;
        for (int i = QUEUE_SIZE - 1; i >= 0; i--) begin
            if (!in_use[i]) begin
                free_slot = SLOT_W'(i);
            end
        end
    end

    assign slots_full = &in_use;
    assign slots_idle = ~|in_use;
    assign lookup_tag = tag_store[lookup_slot];

    // Alloc and release never hit the same slot in one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            in_use <= '0;
        end else begin
            if (release_en) begin
                in_use[release_slot] <= 1'b0;
            end
            if (alloc) begin
                in_use[free_slot] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_store[free_slot] <= alloc_tag;
        end
    end

endmodule

`default_nettype wire

//--- verilog/req_queue.sv
/*
 * Core request queue
 * Circular FIFO of lane requests, each read tagged with its response slot
 */
`default_nettype none

module req_queue (
    input  wire                                clk,
    input  wire                                reset,
    input  wire                                req_valid,
    input  wire                                req_rw,
    input  wire mem_sched_pkg::lane_mask_t     req_mask,
    input  wire mem_sched_pkg::lane_byteen_t   req_byteen,
    input  wire mem_sched_pkg::lane_addr_t     req_addr,
    input  wire mem_sched_pkg::lane_data_t     req_data,
    input  wire [mem_sched_pkg::TAG_W-1:0]     req_tag,
    input  wire [mem_sched_pkg::SLOT_W-1:0]    free_slot,
    input  wire                                slots_full,
    output logic                               req_ready,
    output logic                               alloc,
    output mem_sched_pkg::lane_mask_t          alloc_mask,
    output logic [mem_sched_pkg::TAG_W-1:0]    alloc_tag,
    output logic                               queue_empty,
    queue_head_if.source                       head
);
    import mem_sched_pkg::*;

    logic              q_rw     [QUEUE_SIZE];
    lane_mask_t        q_mask   [QUEUE_SIZE];
    lane_byteen_t      q_byteen [QUEUE_SIZE];
    lane_addr_t        q_addr   [QUEUE_SIZE];
    lane_data_t        q_data   [QUEUE_SIZE];
    logic [SLOT_W-1:0] q_slot   [QUEUE_SIZE];

    logic [SLOT_W-1:0] wr_ptr;
    logic [SLOT_W-1:0] rd_ptr;
    logic [SLOT_W:0]   count;
    logic              push;

    // Reads also need a free response slot
    assign req_ready   = (count != QUEUE_SIZE) && (req_rw || !slots_full);
    assign push        = req_valid && req_ready;
    assign alloc       = push && !req_rw;
    assign alloc_mask  = req_mask;
    assign alloc_tag   = req_tag;
    assign queue_empty = (count == 0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (head.pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (SLOT_W+1)'(push) - (SLOT_W+1)'(head.pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_rw[wr_ptr]     <= req_rw;
            q_mask[wr_ptr]   <= req_mask;
            q_byteen[wr_ptr] <= req_byteen;
            q_addr[wr_ptr]   <= req_addr;
            q_data[wr_ptr]   <= req_data;
            q_slot[wr_ptr]   <= free_slot;
        end
    end

    assign head.valid  = !queue_empty;
    assign head.rw     = q_rw[rd_ptr];
    assign head.mask   = q_mask[rd_ptr];
    assign head.byteen = q_byteen[rd_ptr];
    assign head.addr   = q_addr[rd_ptr];
    assign head.data   = q_data[rd_ptr];
    assign head.slot   = q_slot[rd_ptr];

endmodule

`default_nettype wire

//--- verilog/sched_ifs.sv
/*
 * Scheduler internal interfaces
 * Queue head towards the dispatcher, selected bank response towards the merger
 */
`default_nettype none

interface queue_head_if;
    import mem_sched_pkg::*;

    logic              valid;
    logic              rw;
    lane_mask_t        mask;
    lane_byteen_t      byteen;
    lane_addr_t        addr;
    lane_data_t        data;
    logic [SLOT_W-1:0] slot;
    // Removes the head at the next edge
    logic              pop;

    modport source (output valid, rw, mask, byteen, addr, data, slot, input pop);
    modport sink   (input valid, rw, mask, byteen, addr, data, slot, output pop);
endinterface

interface mem_rsp_if;
    import mem_sched_pkg::*;

    logic                 valid;
    bank_mask_t           bank_mask;
    bank_data_t           data;
    logic [MEM_TAG_W-1:0] tag;
    logic                 ready;

    modport source (output valid, bank_mask, data, tag, input ready);
    modport sink   (input valid, bank_mask, data, tag, output ready);
endinterface

`default_nettype wire

//--- verilog/mem_sched_pkg.sv
/*
 * Memory scheduler shared definitions
 * Request, bank and slot sizes with the per-lane and per-bank types
 */
`default_nettype none

package mem_sched_pkg;

    localparam int NUM_REQS    = 4;
    localparam int NUM_BANKS   = 2;
    localparam int NUM_BATCHES = (NUM_REQS + NUM_BANKS - 1) / NUM_BANKS;
    localparam int ADDR_W      = 16;
    localparam int DATA_W      = 16;
    localparam int BYTEEN_W    = DATA_W / 8;
    localparam int TAG_W       = 4;
    localparam int QUEUE_SIZE  = 4;
    localparam int SLOT_W      = 2;
    localparam int BATCH_W     = 1;
    // Batch index sits above the slot number
    localparam int MEM_TAG_W   = BATCH_W + SLOT_W;

    typedef logic [NUM_REQS-1:0]  lane_mask_t;
    typedef logic [NUM_BANKS-1:0] bank_mask_t;

    typedef logic [NUM_REQS-1:0][ADDR_W-1:0]   lane_addr_t;
    typedef logic [NUM_REQS-1:0][DATA_W-1:0]   lane_data_t;
    typedef logic [NUM_REQS-1:0][BYTEEN_W-1:0] lane_byteen_t;

    typedef logic [NUM_BANKS-1:0][ADDR_W-1:0]    bank_addr_t;
    typedef logic [NUM_BANKS-1:0][DATA_W-1:0]    bank_data_t;
    typedef logic [NUM_BANKS-1:0][BYTEEN_W-1:0]  bank_byteen_t;
    typedef logic [NUM_BANKS-1:0][MEM_TAG_W-1:0] bank_tag_t;

endpackage

`default_nettype wire
